// File: logic/ship_link_defines.svh
//----------------------------------------
// widths, depths and frame constants for the
// ship link, included by the RTL and the testbench
//----------------------------------------
`ifndef SHIP_LINK_DEFINES_SVH
`define SHIP_LINK_DEFINES_SVH

`define WORD_W        16
`define PB_ADDR_W     6
`define PB_DEPTH      64
`define MAC_W         48

`define RX_WORDS      11   // payload words used from a frame
`define TX_WORDS      5    // reply payload words

`define ETHER_TYPE    16'h0A0A
`define MASTER_MAC    48'h0000_0000_0000   // every reply goes here
`define PLAYER1_MAC   48'h0000_0000_0001   // player_number 0
`define PLAYER2_MAC   48'h0000_0000_0002   // player_number 1

`define PAIR_COUNT    28
`define CRYSTAL_COUNT 8

`endif

// File: logic/ship_link_pkg.sv
//----------------------------------------
// shared types for the ship link
// modules import it in their body and use
// scoped names in their port lists
//----------------------------------------
`default_nettype none
`include "ship_link_defines.svh"

package ship_link_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`PB_ADDR_W-1:0] pb_addr_t;
	typedef logic [`MAC_W-1:0] mac_t;   // three words on the wire

	typedef logic [3:0] power_t;   // one crystal pair level

	// index 0 is A-B, then A-C and so on up to G-H at the top
	typedef power_t [`PAIR_COUNT-1:0] power_set_t;

	typedef logic [2:0] crystal_link_t;
	typedef crystal_link_t [`CRYSTAL_COUNT-1:0] crystal_set_t;   // crystal 0 at index 0

	// a received payload word carries either four pair levels
	// or a plain value (sensor nibble, coordinate, checksum)
	typedef union packed {
		power_t [3:0] pwr;   // pwr[0] in the low nibble
		word_t raw;
	} rx_word_u;

endpackage

`default_nettype wire

// File: logic/buffer_port_if.sv
//----------------------------------------
// write and read ports of one packet buffer
// writer and reader views for the blocks,
// mem view for the buffer itself
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface buffer_port_if;
	import ship_link_pkg::*;

	logic wr_en;
	pb_addr_t wr_addr;
	word_t wr_data;
	pb_addr_t rd_addr;
	word_t rd_data;   // word at rd_addr, one clock later

	modport writer (output wr_en, output wr_addr, output wr_data);
	modport reader (output rd_addr, input rd_data);
	modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);
endinterface

`default_nettype wire

// File: logic/packet_buffer.sv
//----------------------------------------
// word-wide packet memory, one write port
// and a registered read port
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "ship_link_defines.svh"

module packet_buffer (
	input logic clk,
	input logic rst_n,
	buffer_port_if.mem mem
);
	import ship_link_pkg::*;

	word_t store [`PB_DEPTH];

	always_ff @(posedge clk)
	begin
		if (mem.wr_en)
			store[mem.wr_addr] <= mem.wr_data;
		mem.rd_data <= store[mem.rd_addr];   // old word on a same-address write
	end

	// writers must stay inside the buffer and never drive an unknown address
	a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		mem.wr_en |-> !$isunknown(mem.wr_addr) && (int'(mem.wr_addr) < `PB_DEPTH));

endmodule

`default_nettype wire

// File: logic/frame_receiver.sv
//----------------------------------------
// pops frames from the show-ahead rx FIFO,
// checks the destination against this player
// and stores matching payloads in the rx buffer
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "ship_link_defines.svh"

module frame_receiver (
	input logic clk,
	input logic rst_n,
	input logic rx_empty,
	input ship_link_pkg::word_t rx_data,
	input logic player_number,
	input logic rx_lock,
	output logic rx_rd,
	output logic frame_found,
	buffer_port_if.writer pb
);
	import ship_link_pkg::*;

	typedef enum logic [1:0] {S_LEN, S_HDR, S_BODY, S_DONE} state_t;
	localparam int HDR_WORDS = 7;   // dst, src, type

	state_t state;
	word_t words_left;   // words of this frame still in the FIFO
	logic [2:0] hdr_idx;
	mac_t dst_mac;
	mac_t my_mac;
	word_t rx_swap;
	logic is_mine;
	logic [`PB_ADDR_W:0] wr_cnt;   // top bit set once the buffer is full

	assign my_mac = player_number ? `PLAYER2_MAC : `PLAYER1_MAC;
	assign rx_swap = {rx_data[7:0], rx_data[15:8]};   // MAC words arrive byte-swapped
	assign rx_rd = (state != S_DONE) && !rx_empty && !rx_lock;

	assign pb.wr_en = rx_rd && (state == S_BODY) && is_mine && (wr_cnt < `PB_DEPTH);
	assign pb.wr_addr = wr_cnt[`PB_ADDR_W-1:0];
	assign pb.wr_data = rx_data;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= S_LEN;
			words_left <= '0;
			hdr_idx <= '0;
			dst_mac <= '0;
			is_mine <= 1'b0;
			wr_cnt <= '0;
			frame_found <= 1'b0;
		end
		else
		begin
			frame_found <= 1'b0;
			case (state)
				S_LEN:
				begin
					if (rx_rd)
					begin
						words_left <= rx_data >> 1;   // bytes to words
						hdr_idx <= '0;
						is_mine <= 1'b0;
						wr_cnt <= '0;
						state <= (rx_data[`WORD_W-1:1] == '0) ? S_DONE : S_HDR;
					end
				end
				S_HDR:
				begin
					if (rx_rd)
					begin
						words_left <= words_left - 1'b1;
						hdr_idx <= hdr_idx + 1'b1;
						if (hdr_idx < 3'd3)
							dst_mac <= {dst_mac[31:0], rx_swap};   // high word first
						if (hdr_idx == 3'd2)
							is_mine <= ({dst_mac[31:0], rx_swap} == my_mac);
						if (words_left == 1)
							state <= S_DONE;   // short frame, no payload
						else if (hdr_idx == HDR_WORDS - 1)
							state <= S_BODY;
					end
				end
				S_BODY:
				begin
					if (rx_rd)
					begin
						words_left <= words_left - 1'b1;
						if (pb.wr_en)
							wr_cnt <= wr_cnt + 1'b1;
						if (words_left == 1)
							state <= S_DONE;
					end
				end
				S_DONE:
				begin
					frame_found <= is_mine;   // other stations get nothing
					state <= S_LEN;
				end
				default: state <= S_LEN;
			endcase
		end
	end

	a_pop_only_when_allowed: assert property (@(posedge clk) disable iff (!rst_n)
		rx_rd |-> !rx_empty && !rx_lock);

endmodule

`default_nettype wire

// File: logic/game_exchange.sv
//----------------------------------------
// unpacks a received frame into the game
// outputs, packs the ship inputs into the tx
// buffer and starts the reply frame
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "ship_link_defines.svh"

module game_exchange (
	input logic clk,
	input logic rst_n,
	input logic frame_found,
	input logic tx_idle,
	input ship_link_pkg::crystal_set_t crystal_links,
	input logic engines_on,
	input logic [1:0] engines_dir,
	input logic [1:0] sensor_move,
	input logic [7:0] sensor_step,
	input logic cannon_fire,
	input logic [9:0] cannon_power,
	input ship_link_pkg::word_t tx_checksum,
	output logic rx_lock,
	output logic send_start,
	output ship_link_pkg::power_set_t power_levels,
	output logic [3:0] sensor_report,
	output ship_link_pkg::word_t x_coord,
	output ship_link_pkg::word_t y_coord,
	output ship_link_pkg::word_t rx_checksum,
	buffer_port_if.reader rx_pb,
	buffer_port_if.writer tx_pb
);
	import ship_link_pkg::*;

	typedef enum logic [2:0] {
		G_IDLE, G_ADDR, G_TAKE, G_PACK, G_WAIT_TX, G_LAUNCH, G_WAIT_DONE
	} state_t;
	localparam int POWER_WORDS = `PAIR_COUNT / 4;   // four levels per word

	state_t state;
	pb_addr_t rd_idx;
	pb_addr_t wr_idx;
	rx_word_u rx_word;
	word_t tx_word;

	assign rx_pb.rd_addr = rd_idx;
	assign rx_word = rx_pb.rd_data;

	assign tx_pb.wr_en = (state == G_PACK);
	assign tx_pb.wr_addr = wr_idx;
	assign tx_pb.wr_data = tx_word;

	// reply payload, one word per buffer slot
	always_comb
	begin
		case (wr_idx)
			6'd0: tx_word = {crystal_links[0], crystal_links[1], crystal_links[2],
				crystal_links[3], engines_on, 3'b000};
			6'd1: tx_word = {crystal_links[4], crystal_links[5], crystal_links[6],
				crystal_links[7], engines_dir, 2'b00};
			6'd2: tx_word = {sensor_step, sensor_move, 6'b000000};
			6'd3: tx_word = {cannon_fire, cannon_power, 5'b00000};
			default: tx_word = tx_checksum;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= G_IDLE;
			rd_idx <= '0;
			wr_idx <= '0;
			rx_lock <= 1'b0;
			send_start <= 1'b0;
			power_levels <= '0;
			sensor_report <= '0;
			x_coord <= '0;
			y_coord <= '0;
			rx_checksum <= '0;
		end
		else
		begin
			send_start <= 1'b0;
			case (state)
				G_IDLE:
				begin
					if (frame_found)
					begin
						rx_lock <= 1'b1;   // receiver keeps off the rx buffer
						rd_idx <= '0;
						state <= G_ADDR;
					end
				end
				G_ADDR: state <= G_TAKE;   // buffer registers the word
				G_TAKE:
				begin
					if (rd_idx < POWER_WORDS)
						power_levels[rd_idx*4 +: 4] <= rx_word.pwr;
					else if (rd_idx == POWER_WORDS)
						sensor_report <= rx_word.raw[3:0];
					else if (rd_idx == POWER_WORDS + 1)
						x_coord <= rx_word.raw;
					else if (rd_idx == POWER_WORDS + 2)
						y_coord <= rx_word.raw;
					else
						rx_checksum <= rx_word.raw;
					rd_idx <= rd_idx + 1'b1;
					if (rd_idx == `RX_WORDS - 1)
					begin
						rx_lock <= 1'b0;
						wr_idx <= '0;
						state <= G_PACK;
					end
					else
						state <= G_ADDR;
				end
				G_PACK:
				begin
					wr_idx <= wr_idx + 1'b1;
					if (wr_idx == `TX_WORDS - 1)
						state <= G_WAIT_TX;
				end
				G_WAIT_TX:
				begin
					if (tx_idle)
					begin
						send_start <= 1'b1;
						state <= G_LAUNCH;
					end
				end
				G_LAUNCH: state <= G_WAIT_DONE;   // sender leaves idle on this edge
				G_WAIT_DONE:
				begin
					if (tx_idle)
						state <= G_IDLE;
				end
				default: state <= G_IDLE;
			endcase
		end
	end

	// the sender must be free whenever a reply is launched
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		send_start |-> tx_idle);

endmodule

`default_nettype wire

// File: logic/frame_sender.sv
//----------------------------------------
// writes the reply frame into the tx FIFO,
// header first, then the payload from the
// tx buffer, holding each word under full
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "ship_link_defines.svh"

module frame_sender (
	input logic clk,
	input logic rst_n,
	input logic send_start,
	input logic tx_full,
	output logic tx_idle,
	output logic tx_wr,
	output ship_link_pkg::word_t tx_data,
	buffer_port_if.reader pb
);
	import ship_link_pkg::*;

	typedef enum logic [1:0] {T_IDLE, T_HDR, T_DATA} state_t;
	localparam int HDR_WORDS = 5;   // length, destination, type
	localparam mac_t DEST_MAC = `MASTER_MAC;

	state_t state;
	logic [2:0] hdr_idx;
	pb_addr_t pay_idx;
	logic data_adv;
	word_t hdr_word;

	assign tx_idle = (state == T_IDLE);
	assign tx_wr = (state != T_IDLE) && !tx_full;
	assign data_adv = (state == T_DATA) && tx_wr;
	// runs one ahead on a write so the next word is there a clock later
	assign pb.rd_addr = pay_idx + pb_addr_t'(data_adv);
	assign tx_data = (state == T_DATA) ? pb.rd_data : hdr_word;

	always_comb
	begin
		case (hdr_idx)
			3'd0: hdr_word = word_t'(`TX_WORDS * 2);   // byte count
			3'd1: hdr_word = DEST_MAC[47:32];
			3'd2: hdr_word = DEST_MAC[31:16];
			3'd3: hdr_word = DEST_MAC[15:0];
			default: hdr_word = `ETHER_TYPE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= T_IDLE;
			hdr_idx <= '0;
			pay_idx <= '0;
		end
		else
		begin
			case (state)
				T_IDLE:
				begin
					hdr_idx <= '0;
					pay_idx <= '0;   // word 0 prefetched during the header
					if (send_start)
						state <= T_HDR;
				end
				T_HDR:
				begin
					if (tx_wr)
					begin
						hdr_idx <= hdr_idx + 1'b1;
						if (hdr_idx == HDR_WORDS - 1)
							state <= T_DATA;
					end
				end
				T_DATA:
				begin
					if (tx_wr)
					begin
						pay_idx <= pay_idx + 1'b1;
						if (pay_idx == `TX_WORDS - 1)
							state <= T_IDLE;
					end
				end
				default: state <= T_IDLE;
			endcase
		end
	end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		tx_wr |-> !tx_full);

endmodule

`default_nettype wire

// File: logic/ship_link_top.sv
//----------------------------------------
// game-side network link: rx FIFO in, game
// state out, ship state back through tx FIFO
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ship_link_top (
	input logic clk,
	input logic rst_n,
	input logic player_number,
	input logic rx_empty,   // show-ahead rx FIFO
	input ship_link_pkg::word_t rx_data,
	output logic rx_rd,
	input logic tx_full,
	output logic tx_wr,
	output ship_link_pkg::word_t tx_data,
	input ship_link_pkg::crystal_set_t crystal_links,
	input logic engines_on,
	input logic [1:0] engines_dir,
	input logic [1:0] sensor_move,
	input logic [7:0] sensor_step,
	input logic cannon_fire,
	input logic [9:0] cannon_power,
	input ship_link_pkg::word_t tx_checksum,
	output ship_link_pkg::power_set_t power_levels,
	output logic [3:0] sensor_report,
	output ship_link_pkg::word_t x_coord,
	output ship_link_pkg::word_t y_coord,
	output ship_link_pkg::word_t rx_checksum
);
	logic frame_found;
	logic rx_lock;
	logic send_start;
	logic tx_idle;

	buffer_port_if rx_port ();
	buffer_port_if tx_port ();

	packet_buffer rx_buf (.clk(clk), .rst_n(rst_n), .mem(rx_port.mem));
	packet_buffer tx_buf (.clk(clk), .rst_n(rst_n), .mem(tx_port.mem));

	frame_receiver receiver (
		.clk(clk),
		.rst_n(rst_n),
		.rx_empty(rx_empty),
		.rx_data(rx_data),
		.player_number(player_number),
		.rx_lock(rx_lock),
		.rx_rd(rx_rd),
		.frame_found(frame_found),
		.pb(rx_port.writer)
	);

	game_exchange exchange (
		.clk(clk),
		.rst_n(rst_n),
		.frame_found(frame_found),
		.tx_idle(tx_idle),
		.crystal_links(crystal_links),
		.engines_on(engines_on),
		.engines_dir(engines_dir),
		.sensor_move(sensor_move),
		.sensor_step(sensor_step),
		.cannon_fire(cannon_fire),
		.cannon_power(cannon_power),
		.tx_checksum(tx_checksum),
		.rx_lock(rx_lock),
		.send_start(send_start),
		.power_levels(power_levels),
		.sensor_report(sensor_report),
		.x_coord(x_coord),
		.y_coord(y_coord),
		.rx_checksum(rx_checksum),
		.rx_pb(rx_port.reader),
		.tx_pb(tx_port.writer)
	);

	frame_sender sender (
		.clk(clk),
		.rst_n(rst_n),
		.send_start(send_start),
		.tx_full(tx_full),
		.tx_idle(tx_idle),
		.tx_wr(tx_wr),
		.tx_data(tx_data),
		.pb(tx_port.reader)
	);

endmodule

`default_nettype wire

// File: sim/tb_ship_link.sv
//----------------------------------------
// table-driven testbench for ship_link_top
// models the show-ahead rx FIFO and the tx
// FIFO, checks game outputs and reply words
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "ship_link_defines.svh"

module tb_ship_link;
	import ship_link_pkg::*;

	localparam int ENTRY_COUNT = 6;
	localparam int REPLY_WORDS = 5 + `TX_WORDS;   // length, MAC, type, payload
	localparam int WAIT_LIMIT = 300;   // cycles per entry
	localparam int SETTLE = 80;   // long enough for a stray reply to show up
	localparam longint WATCHDOG_NS = ENTRY_COUNT * 400 * 40;

	typedef struct packed {
		logic player;
		logic to_me;   // low sends to the other player's address
		logic [6:0] full_pct;
		logic [31:0] seed;
	} entry_t;

	entry_t tests [ENTRY_COUNT] = '{
		'{1'b0, 1'b1, 7'd0, 32'h3c9e4a17},
		'{1'b0, 1'b1, 7'd40, 32'h81d255e2},
		'{1'b0, 1'b0, 7'd25, 32'h0f6bc3a9},
		'{1'b1, 1'b1, 7'd60, 32'h5e0791d3},
		'{1'b1, 1'b0, 7'd50, 32'hc4a82b6e},
		'{1'b1, 1'b1, 7'd80, 32'h9273e0f1}
	};

	logic clk;
	logic rst_n;
	logic player_number;
	logic rx_empty = 1'b1;
	word_t rx_data = '0;
	logic rx_rd;
	logic tx_full = 1'b0;
	logic tx_wr;
	word_t tx_data;
	crystal_set_t crystal_links;
	logic engines_on;
	logic [1:0] engines_dir;
	logic [1:0] sensor_move;
	logic [7:0] sensor_step;
	logic cannon_fire;
	logic [9:0] cannon_power;
	word_t tx_checksum;
	power_set_t power_levels;
	logic [3:0] sensor_report;
	word_t x_coord;
	word_t y_coord;
	word_t rx_checksum;

	word_t rx_q [$];   // rx FIFO contents, head is shown
	word_t tx_cap [$];   // words taken from tx_wr
	logic pop_pending;
	int full_pct;
	int err_count = 0;
	int proto_errors = 0;
	int check_count = 0;
	power_set_t exp_power;
	logic [3:0] exp_sensor;
	word_t exp_x;
	word_t exp_y;
	word_t exp_sum;

	ship_link_top UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// DUT outputs sampled before the edge updates them
	always @(posedge clk)
	begin
		pop_pending <= rx_rd;
		if (rx_rd && rx_empty)
		begin
			$display("rx_rd went high at %0t ns while the rx FIFO was empty", $time);
			proto_errors++;
		end
		if (tx_wr)
		begin
			tx_cap.push_back(tx_data);
			if (tx_full)
			begin
				$display("tx_wr went high at %0t ns while tx_full was high", $time);
				proto_errors++;
			end
		end
	end

	always @(negedge clk)
	begin
		if (pop_pending === 1'b1 && rx_q.size() > 0)
			void'(rx_q.pop_front());
		rx_empty = (rx_q.size() == 0);
		rx_data = rx_empty ? '0 : rx_q[0];
		tx_full = rst_n && ($urandom_range(99) < full_pct);
	end

	function automatic logic [31:0] next_pseudo(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t byte_swap(input word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			err_count++;
		end
	endtask

	task automatic check_game_outputs();
		check_value("power_levels", exp_power, power_levels);
		check_value("sensor_report", exp_sensor, sensor_report);
		check_value("x_coord", exp_x, x_coord);
		check_value("y_coord", exp_y, y_coord);
		check_value("rx_checksum", exp_sum, rx_checksum);
	endtask

	task automatic drive_ship_inputs(input logic [31:0] seed);
		logic [31:0] s;
		s = next_pseudo(seed);
		crystal_links = s[23:0];
		engines_on = s[24];
		engines_dir = s[26:25];
		sensor_move = s[28:27];
		s = next_pseudo(s);
		sensor_step = s[7:0];
		cannon_fire = s[8];
		cannon_power = s[18:9];
		tx_checksum = s[31:16];
	endtask

	// words 0-6 carry four levels each, lowest nibble first
	task automatic note_payload_word(input int idx, input word_t w);
		if (idx < `PAIR_COUNT / 4)
		begin
			for (int j = 0; j < 4; j++)
				exp_power[4*idx + j] = w[4*j +: 4];
		end
		else if (idx == 7)
			exp_sensor = w[3:0];
		else if (idx == 8)
			exp_x = w;
		else if (idx == 9)
			exp_y = w;
		else
			exp_sum = w;
	endtask

	task automatic feed_frame(input entry_t e);
		logic [31:0] s;
		mac_t dst;
		word_t frame [$];
		int n_pay;
		s = next_pseudo(e.seed ^ 32'h5a5a0f0f);
		if (e.to_me)
			dst = e.player ? `PLAYER2_MAC : `PLAYER1_MAC;
		else
			dst = e.player ? `PLAYER1_MAC : `PLAYER2_MAC;
		n_pay = `RX_WORDS + int'(e.seed[1:0]);   // some frames carry spare words
		frame.push_back(word_t'((7 + n_pay) * 2));
		for (int i = 2; i >= 0; i--)
			frame.push_back(byte_swap(dst[i*16 +: 16]));
		for (int i = 0; i < 3; i++)
			frame.push_back(s[15:0] ^ word_t'(i));   // source MAC, ignored
		frame.push_back(`ETHER_TYPE);
		for (int i = 0; i < n_pay; i++)
		begin
			s = next_pseudo(s);
			frame.push_back(s[15:0]);
			if (e.to_me && i < `RX_WORDS)
				note_payload_word(i, s[15:0]);
		end
		@(posedge clk);
		full_pct = int'(e.full_pct);
		foreach (frame[i])
			rx_q.push_back(frame[i]);
	endtask

	task automatic wait_for_entry(input int idx, input logic expect_reply);
		int cycles;
		cycles = 0;
		if (expect_reply)
		begin
			while (tx_cap.size() < REPLY_WORDS && cycles < WAIT_LIMIT)
			begin
				@(negedge clk);
				cycles++;
			end
		end
		else
		begin
			while (rx_q.size() != 0 && cycles < WAIT_LIMIT)
			begin
				@(posedge clk);
				cycles++;
			end
		end
		if (cycles >= WAIT_LIMIT)
		begin
			$display("entry %0d: frame or reply not done after %0d cycles", idx, WAIT_LIMIT);
			err_count++;
		end
	endtask

	task automatic check_reply();
		mac_t master;
		word_t expected [REPLY_WORDS];
		master = `MASTER_MAC;
		expected = '{default: '0};
		expected[0] = word_t'(`TX_WORDS * 2);
		expected[1] = master[47:32];
		expected[2] = master[31:16];
		expected[3] = master[15:0];
		expected[4] = `ETHER_TYPE;
		// crystals fill three-bit fields from the top of payload words 0 and 1
		for (int k = 0; k < 4; k++)
		begin
			expected[5][15 - 3*k -: 3] = crystal_links[k];
			expected[6][15 - 3*k -: 3] = crystal_links[k + 4];
		end
		expected[5][3] = engines_on;
		expected[6][3:2] = engines_dir;
		expected[7][15:8] = sensor_step;
		expected[7][7:6] = sensor_move;
		expected[8][15] = cannon_fire;
		expected[8][14:5] = cannon_power;
		expected[9] = tx_checksum;
		check_value("reply word count", REPLY_WORDS, tx_cap.size());
		for (int i = 0; i < REPLY_WORDS && i < tx_cap.size(); i++)
			check_value($sformatf("tx_data word %0d", i), expected[i], tx_cap[i]);
	endtask

	task automatic run_entry(input int idx, input entry_t e);
		@(negedge clk);
		player_number = e.player;
		drive_ship_inputs(e.seed);   // held until the reply is checked
		feed_frame(e);
		wait_for_entry(idx, e.to_me);
		repeat (SETTLE) @(posedge clk);
		@(negedge clk);
		if (e.to_me)
			check_reply();
		else
			check_value("reply word count", 0, tx_cap.size());
		tx_cap.delete();
		check_value("rx FIFO words left", 0, rx_q.size());
		check_game_outputs();
	endtask

	initial
	begin
		void'($urandom(32'h176c694c));
		rst_n = 1'b0;
		player_number = 1'b0;
		drive_ship_inputs(32'h0);   // zero seed gives all zeros
		full_pct = 0;
		exp_power = '0;
		exp_sensor = '0;
		exp_x = '0;
		exp_y = '0;
		exp_sum = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_game_outputs();
		check_value("rx_rd", 0, rx_rd);
		check_value("tx_wr", 0, tx_wr);
		for (int i = 0; i < ENTRY_COUNT; i++)
			run_entry(i, tests[i]);
		$display("checks: %0d, value errors: %0d, FIFO protocol errors: %0d",
			check_count, err_count, proto_errors);
		if (err_count + proto_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/ship_link_pkg.sv
logic/buffer_port_if.sv
logic/packet_buffer.sv
logic/frame_receiver.sv
logic/game_exchange.sv
logic/frame_sender.sv
logic/ship_link_top.sv
sim/tb_ship_link.sv

// File: run_sim.sh
#!/bin/sh
# builds the ship link testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_ship_link
out=$(./obj_dir/Vtb_ship_link)
echo "$out"
if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
